//--- hw/noc_pkg.sv
package noc_pkg;

    // flit layout, from the top bit down.
    // kind(2) | dst z,y,x (9) | src z,y,x (9) | packet number (8) | flit index (4)
    localparam int FLIT_W    = 32;
    localparam int KIND_W    = 2;
    localparam int COORD_W   = 3;
    localparam int PKT_NUM_W = 8;
    localparam int IDX_W     = 4;

    localparam int NUM_DIRS  = 6;
    localparam int COUNT_W   = 16;

    typedef logic [FLIT_W-1:0] flit_t;

    typedef enum logic [KIND_W-1:0] {
        HEAD         = 2'd0,
        BODY         = 2'd1,
        TAIL         = 2'd2,
        INVALID_KIND = 2'd3
    } flit_kind_e;

    // port arrays are indexed by this.
    typedef enum logic [2:0] {
        XPOS = 3'd0,
        YPOS = 3'd1,
        ZPOS = 3'd2,
        XNEG = 3'd3,
        YNEG = 3'd4,
        ZNEG = 3'd5
    } port_dir_e;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        RCVING = 2'd1,
        FAILED = 2'd2
    } chk_state_e;

    typedef enum logic [1:0] {
        NO_ERROR     = 2'd0,
        FLIT_WRONG   = 2'd1,
        FLIT_MISSING = 2'd2,
        FLIT_TIMEOUT = 2'd3
    } err_code_e;

endpackage

//--- hw/injection_pacer.sv
`timescale 1ns/10ps

module injection_pacer import noc_pkg::*; #(
    parameter int injection_rate = 30,
    parameter int packet_size    = 16,
    parameter int packet_num     = 10
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fifo_room,
    output logic                 beat_valid,
    output logic [IDX_W-1:0]     flit_idx,
    output logic [PKT_NUM_W-1:0] pkt_num
);

    localparam int RATE_W = (injection_rate > 1) ? $clog2(injection_rate) : 1;

    logic [RATE_W-1:0]    rate_cnt;
    logic [PKT_NUM_W-1:0] pkts_started;
    logic                 active;
    logic                 rate_tick;
    logic                 last_beat;

    assign rate_tick  = (rate_cnt == RATE_W'(injection_rate - 1));
    assign beat_valid = active && fifo_room;
    assign last_beat  = (flit_idx == IDX_W'(packet_size - 1));

    // number of the packet in progress.
    assign pkt_num = pkts_started - PKT_NUM_W'(1);

    always_ff @(posedge clk) begin
        if (rst || rate_tick) begin
            rate_cnt <= '0;
        end else begin
            rate_cnt <= rate_cnt + RATE_W'(1);
        end
    end

    // ticks seen while a packet is in progress are dropped.
    always_ff @(posedge clk) begin
        if (rst) begin
            active       <= 1'b0;
            flit_idx     <= '0;
            pkts_started <= '0;
        end else if (!active) begin
            if (rate_tick && (pkts_started < PKT_NUM_W'(packet_num))) begin
                active       <= 1'b1;
                flit_idx     <= '0;
                pkts_started <= pkts_started + PKT_NUM_W'(1);
            end
        end else if (beat_valid) begin
            if (last_beat) begin
                active <= 1'b0;
            end else begin
                flit_idx <= flit_idx + IDX_W'(1);
            end
        end
    end

endmodule

//--- hw/flit_formatter.sv
`timescale 1ns/10ps

module flit_formatter import noc_pkg::*; #(
    parameter int cur_x       = 0,
    parameter int cur_y       = 0,
    parameter int cur_z       = 0,
    parameter int x_size      = 4,
    parameter int y_size      = 4,
    parameter int z_size      = 4,
    parameter int packet_size = 16
) (
    input  logic [IDX_W-1:0]     flit_idx,
    input  logic [PKT_NUM_W-1:0] pkt_num,
    output flit_t                fmt_data [NUM_DIRS]
);

    // torus neighbours, each axis wraps at its own size.
    localparam logic [COORD_W-1:0] NXT_X = COORD_W'((cur_x == x_size - 1) ? 0 : cur_x + 1);
    localparam logic [COORD_W-1:0] NXT_Y = COORD_W'((cur_y == y_size - 1) ? 0 : cur_y + 1);
    localparam logic [COORD_W-1:0] NXT_Z = COORD_W'((cur_z == z_size - 1) ? 0 : cur_z + 1);
    localparam logic [COORD_W-1:0] PRE_X = COORD_W'((cur_x == 0) ? x_size - 1 : cur_x - 1);
    localparam logic [COORD_W-1:0] PRE_Y = COORD_W'((cur_y == 0) ? y_size - 1 : cur_y - 1);
    localparam logic [COORD_W-1:0] PRE_Z = COORD_W'((cur_z == 0) ? z_size - 1 : cur_z - 1);

    localparam logic [COORD_W-1:0] OWN_X = COORD_W'(cur_x);
    localparam logic [COORD_W-1:0] OWN_Y = COORD_W'(cur_y);
    localparam logic [COORD_W-1:0] OWN_Z = COORD_W'(cur_z);

    flit_kind_e kind;

    always_comb begin
        if (flit_idx == '0) begin
            kind = HEAD;
        end else if (flit_idx == IDX_W'(packet_size - 1)) begin
            kind = TAIL;
        end else begin
            kind = BODY;
        end
    end

    always_comb begin
        logic [COORD_W-1:0] dst_x;
        logic [COORD_W-1:0] dst_y;
        logic [COORD_W-1:0] dst_z;
        for (int d = 0; d < NUM_DIRS; d++) begin
            dst_x = OWN_X;
            dst_y = OWN_Y;
            dst_z = OWN_Z;
            case (port_dir_e'(d))
                XPOS:    dst_x = NXT_X;
                YPOS:    dst_y = NXT_Y;
                ZPOS:    dst_z = NXT_Z;
                XNEG:    dst_x = PRE_X;
                YNEG:    dst_y = PRE_Y;
                default: dst_z = PRE_Z;
            endcase
            fmt_data[d] = {kind, dst_z, dst_y, dst_x, OWN_Z, OWN_Y, OWN_X, pkt_num, flit_idx};
        end
    end

endmodule

//--- hw/inject_fifo.sv
`timescale 1ns/10ps

module inject_fifo import noc_pkg::*; #(
    parameter int fifo_depth = 64
) (
    input  logic  clk,
    input  logic  rst,
    input  flit_t wr_data,
    input  logic  wr_en,
    input  logic  rd_ready,
    output logic  wr_ready,
    output flit_t rd_data,
    output logic  rd_valid
);

    localparam int PTR_W = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int CNT_W = $clog2(fifo_depth + 1);

    flit_t             mem [fifo_depth];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_wr;
    logic              do_rd;

    assign wr_ready = (count != CNT_W'(fifo_depth));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];

    assign do_wr = wr_en && wr_ready;
    assign do_rd = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(fifo_depth - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(fifo_depth - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            // write and read in one cycle leave the count alone.
            if (do_wr && !do_rd) begin
                count <= count + CNT_W'(1);
            end else if (do_rd && !do_wr) begin
                count <= count - CNT_W'(1);
            end
        end
    end

endmodule

//--- hw/eject_checker.sv
`timescale 1ns/10ps

module eject_checker import noc_pkg::*; #(
    parameter int packet_size  = 16,
    parameter int flit_timeout = 1000
) (
    input  logic               clk,
    input  logic               rst,
    input  flit_t              flit_in,
    input  logic               flit_valid,
    output logic [COUNT_W-1:0] pckt_count,
    output err_code_e          err_code
);

    localparam int TO_W = $clog2(flit_timeout + 1);

    // flits seen before the tail of a complete packet.
    localparam logic [COUNT_W-1:0] PRE_TAIL = COUNT_W'(packet_size - 1);

    chk_state_e         state;
    flit_kind_e         kind;
    logic [COUNT_W-1:0] flit_cnt;
    logic [TO_W-1:0]    idle_cnt;

    assign kind = flit_kind_e'(flit_in[FLIT_W-1 -: KIND_W]);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            flit_cnt   <= '0;
            idle_cnt   <= '0;
            pckt_count <= '0;
            err_code   <= NO_ERROR;
        end else begin
            case (state)
                IDLE: begin
                    if (flit_valid) begin
                        if (kind == HEAD) begin
                            state    <= RCVING;
                            flit_cnt <= COUNT_W'(1);
                            idle_cnt <= '0;
                        end else begin
                            state    <= FAILED;
                            err_code <= FLIT_WRONG;
                        end
                    end
                end
                RCVING: begin
                    if (flit_valid) begin
                        idle_cnt <= '0;
                        case (kind)
                            BODY: begin
                                // saturate so a runaway body stream still reads as too long.
                                if (flit_cnt != '1) begin
                                    flit_cnt <= flit_cnt + COUNT_W'(1);
                                end
                            end
                            TAIL: begin
                                if (flit_cnt < PRE_TAIL) begin
                                    state    <= FAILED;
                                    err_code <= FLIT_MISSING;
                                end else if (flit_cnt > PRE_TAIL) begin
                                    state    <= FAILED;
                                    err_code <= FLIT_WRONG;
                                end else begin
                                    state      <= IDLE;
                                    pckt_count <= pckt_count + COUNT_W'(1);
                                end
                            end
                            default: begin
                                state    <= FAILED;
                                err_code <= FLIT_MISSING;
                            end
                        endcase
                    end else if (idle_cnt == TO_W'(flit_timeout)) begin
                        state    <= FAILED;
                        err_code <= FLIT_TIMEOUT;
                    end else begin
                        idle_cnt <= idle_cnt + TO_W'(1);
                    end
                end
                default: begin
                    // failed is held until reset.
                    state <= FAILED;
                end
            endcase
        end
    end

endmodule

//--- hw/local_unit.sv
`timescale 1ns/10ps

module local_unit import noc_pkg::*; #(
    parameter int cur_x          = 0,
    parameter int cur_y          = 0,
    parameter int cur_z          = 0,
    parameter int x_size         = 4,
    parameter int y_size         = 4,
    parameter int z_size         = 4,
    parameter int injection_rate = 30,
    parameter int packet_size    = 16,
    parameter int packet_num     = 10,
    parameter int fifo_depth     = 64,
    parameter int flit_timeout   = 1000
) (
    input  logic               clk,
    input  logic               rst,
    input  flit_t              eject_data [NUM_DIRS],
    input  logic               eject_valid [NUM_DIRS],
    input  logic               inject_ready [NUM_DIRS],
    output flit_t              inject_data [NUM_DIRS],
    output logic               inject_valid [NUM_DIRS],
    output logic [COUNT_W-1:0] pckt_count [NUM_DIRS],
    output err_code_e          err_code [NUM_DIRS],
    output logic               all_pckts_rcvd
);

    // sum of six counters needs three extra bits.
    localparam int SUM_W = COUNT_W + 3;
    localparam int TOTAL_PCKTS = NUM_DIRS * packet_num;

    logic                 beat_valid;
    logic                 fifo_wr;
    logic                 fifo_room;
    logic [IDX_W-1:0]     flit_idx;
    logic [PKT_NUM_W-1:0] pkt_num;
    logic [NUM_DIRS-1:0]  wr_ready;
    flit_t                fmt_data [NUM_DIRS];
    logic [SUM_W-1:0]     count_sum;

    // a beat goes out only when every direction has room.
    assign fifo_room = &wr_ready;
    assign fifo_wr   = beat_valid;

    injection_pacer #(
        .injection_rate (injection_rate),
        .packet_size    (packet_size),
        .packet_num     (packet_num)
    ) u_pacer (
        .clk        (clk),
        .rst        (rst),
        .fifo_room  (fifo_room),
        .beat_valid (beat_valid),
        .flit_idx   (flit_idx),
        .pkt_num    (pkt_num)
    );

    flit_formatter #(
        .cur_x       (cur_x),
        .cur_y       (cur_y),
        .cur_z       (cur_z),
        .x_size      (x_size),
        .y_size      (y_size),
        .z_size      (z_size),
        .packet_size (packet_size)
    ) u_formatter (
        .flit_idx (flit_idx),
        .pkt_num  (pkt_num),
        .fmt_data (fmt_data)
    );

    for (genvar d = 0; d < NUM_DIRS; d++) begin : g_dir
        inject_fifo #(
            .fifo_depth (fifo_depth)
        ) u_fifo (
            .clk      (clk),
            .rst      (rst),
            .wr_data  (fmt_data[d]),
            .wr_en    (fifo_wr),
            .rd_ready (inject_ready[d]),
            .wr_ready (wr_ready[d]),
            .rd_data  (inject_data[d]),
            .rd_valid (inject_valid[d])
        );

        eject_checker #(
            .packet_size  (packet_size),
            .flit_timeout (flit_timeout)
        ) u_checker (
            .clk        (clk),
            .rst        (rst),
            .flit_in    (eject_data[d]),
            .flit_valid (eject_valid[d]),
            .pckt_count (pckt_count[d]),
            .err_code   (err_code[d])
        );
    end

    always_comb begin
        count_sum = '0;
        for (int d = 0; d < NUM_DIRS; d++) begin
            count_sum = count_sum + SUM_W'(pckt_count[d]);
        end
    end

    // once set, the flag holds until reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            all_pckts_rcvd <= 1'b0;
        end else if (count_sum >= SUM_W'(TOTAL_PCKTS)) begin
            all_pckts_rcvd <= 1'b1;
        end
    end

endmodule

//--- tests/local_unit_chk.sv
`timescale 1ns/10ps

module local_unit_chk import noc_pkg::*; (
    input logic      clk,
    input logic      rst,
    input flit_t     inject_data [NUM_DIRS],
    input logic      inject_valid [NUM_DIRS],
    input logic      inject_ready [NUM_DIRS],
    input err_code_e err_code [NUM_DIRS]
);

    int assert_fails = 0;

    for (genvar d = 0; d < NUM_DIRS; d++) begin : g_dir
        // a waiting flit keeps its valid and its data.
        assert property (@(posedge clk) disable iff (rst)
            inject_valid[d] && !inject_ready[d] |=> inject_valid[d] && $stable(inject_data[d]))
        else begin
            assert_fails++;
            $error("inject port %0d dropped or changed a flit before ready", d);
        end

        assert property (@(posedge clk) rst |=> !inject_valid[d])
        else begin
            assert_fails++;
            $error("inject port %0d is valid while in reset", d);
        end

        // error codes are sticky until reset.
        assert property (@(posedge clk) disable iff (rst)
            err_code[d] != NO_ERROR |=> err_code[d] != NO_ERROR)
        else begin
            assert_fails++;
            $error("eject port %0d cleared its error code without reset", d);
        end
    end

endmodule

bind local_unit local_unit_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .inject_data  (inject_data),
    .inject_valid (inject_valid),
    .inject_ready (inject_ready),
    .err_code     (err_code)
);

//--- tests/local_unit_mon.sv
`timescale 1ns/10ps

module local_unit_mon import noc_pkg::*; #(
    parameter int total_flits = 160
) (
    input  logic               clk,
    input  logic               rst,
    input  flit_t              inject_data [NUM_DIRS],
    input  logic               inject_valid [NUM_DIRS],
    input  logic               inject_ready [NUM_DIRS],
    input  logic [COUNT_W-1:0] pckt_count [NUM_DIRS],
    input  err_code_e          err_code [NUM_DIRS],
    input  logic               all_pckts_rcvd,
    input  flit_t              exp_flits [NUM_DIRS*total_flits],
    input  logic               check_en,
    input  int                 exp_count [NUM_DIRS],
    input  err_code_e          exp_err [NUM_DIRS],
    input  logic               exp_all,
    output logic               done,
    output int                 mismatches
);

    int rcv_idx [NUM_DIRS];

    initial begin
        mismatches = 0;
        done       = 1'b0;
    end

    always @(posedge clk) begin
        if (rst) begin
            for (int d = 0; d < NUM_DIRS; d++) begin
                rcv_idx[d] = 0;
            end
            done = 1'b0;
        end else begin
            done = 1'b1;
            for (int d = 0; d < NUM_DIRS; d++) begin
                if (inject_valid[d] && inject_ready[d]) begin
                    if (rcv_idx[d] >= total_flits) begin
                        mismatches++;
                        $display("Error: time %0t: inject port %0d sent a flit past the last one",
                                 $time, d);
                    end else if (inject_data[d] !== exp_flits[d*total_flits + rcv_idx[d]]) begin
                        mismatches++;
                        $display("Error: time %0t: inject port %0d flit %0d is %h, expected %h",
                                 $time, d, rcv_idx[d], inject_data[d],
                                 exp_flits[d*total_flits + rcv_idx[d]]);
                    end
                    rcv_idx[d]++;
                end
                if (rcv_idx[d] != total_flits) begin
                    done = 1'b0;
                end
            end
        end

        // counts and error codes are compared only when the testbench asks.
        if (check_en) begin
            for (int d = 0; d < NUM_DIRS; d++) begin
                if (pckt_count[d] !== COUNT_W'(exp_count[d])) begin
                    mismatches++;
                    $display("Error: time %0t: eject port %0d counted %0d packets, expected %0d",
                             $time, d, pckt_count[d], exp_count[d]);
                end
                if (err_code[d] !== exp_err[d]) begin
                    mismatches++;
                    $display("Error: time %0t: eject port %0d error code %0d, expected %0d",
                             $time, d, err_code[d], exp_err[d]);
                end
            end
            if (all_pckts_rcvd !== exp_all) begin
                mismatches++;
                $display("Error: time %0t: all_pckts_rcvd is %b, expected %b",
                         $time, all_pckts_rcvd, exp_all);
            end
        end
    end

endmodule

//--- tests/tb_local_unit.sv
`timescale 1ns/10ps

module tb_local_unit import noc_pkg::*; ();

    localparam int PACKET_SIZE = 16;
    localparam int PACKET_NUM  = 10;
    localparam int TOTAL_FLITS = PACKET_SIZE * PACKET_NUM;
    localparam int TORUS_SIZE  = 4;
    localparam int CUR_X       = 1;
    localparam int CUR_Y       = 3;
    localparam int CUR_Z       = 0;

    // conditions that wait_until can poll.
    localparam int W_XPOS_FULL   = 0;
    localparam int W_INJECT_DONE = 1;
    localparam int W_ERRORS      = 2;
    localparam int W_ALL_RCVD    = 3;

    logic               clk = 1'b0;
    logic               rst = 1'b1;
    flit_t              eject_data [NUM_DIRS];
    logic               eject_valid [NUM_DIRS];
    logic               inject_ready [NUM_DIRS];
    flit_t              inject_data [NUM_DIRS];
    logic               inject_valid [NUM_DIRS];
    logic [COUNT_W-1:0] pckt_count [NUM_DIRS];
    err_code_e          err_code [NUM_DIRS];
    logic               all_pckts_rcvd;

    flit_t       exp_flits [NUM_DIRS*TOTAL_FLITS];
    int          exp_count [NUM_DIRS];
    err_code_e   exp_err [NUM_DIRS];
    logic        exp_all = 1'b0;
    logic        check_en = 1'b0;
    logic        hold_xpos = 1'b1;
    logic        done;
    int          mismatches;
    int          timeouts = 0;
    logic [31:0] lfsr = 32'hb8eb_2a73;

    local_unit #(
        .cur_x        (CUR_X),
        .cur_y        (CUR_Y),
        .cur_z        (CUR_Z),
        .flit_timeout (40)
    ) DUT (.*);

    local_unit_mon #(.total_flits(TOTAL_FLITS)) u_mon (.*);

    initial begin
        forever begin
            #2 clk = ~clk;
        end
    end

    // fibonacci lfsr on x^32 + x^22 + x^2 + x + 1.
    function automatic logic rand_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    // neighbour in each direction wraps modulo the axis size.
    function automatic flit_t expected_flit(input port_dir_e dir, input int pkt, input int idx);
        int         dx;
        int         dy;
        int         dz;
        flit_kind_e kind;
        dx = CUR_X;
        dy = CUR_Y;
        dz = CUR_Z;
        case (dir)
            XPOS:    dx = (CUR_X + 1) % TORUS_SIZE;
            YPOS:    dy = (CUR_Y + 1) % TORUS_SIZE;
            ZPOS:    dz = (CUR_Z + 1) % TORUS_SIZE;
            XNEG:    dx = (CUR_X + TORUS_SIZE - 1) % TORUS_SIZE;
            YNEG:    dy = (CUR_Y + TORUS_SIZE - 1) % TORUS_SIZE;
            default: dz = (CUR_Z + TORUS_SIZE - 1) % TORUS_SIZE;
        endcase
        if (idx == 0) begin
            kind = HEAD;
        end else if (idx == PACKET_SIZE - 1) begin
            kind = TAIL;
        end else begin
            kind = BODY;
        end
        return {kind, COORD_W'(dz), COORD_W'(dy), COORD_W'(dx), COORD_W'(CUR_Z),
                COORD_W'(CUR_Y), COORD_W'(CUR_X), PKT_NUM_W'(pkt), IDX_W'(idx)};
    endfunction

    function automatic logic cond_met(input int which);
        case (which)
            W_XPOS_FULL:   return !DUT.wr_ready[XPOS];
            W_INJECT_DONE: return done;
            W_ERRORS:      return err_code[XNEG] != NO_ERROR && err_code[YNEG] != NO_ERROR
                                  && err_code[ZNEG] != NO_ERROR;
            default:       return all_pckts_rcvd;
        endcase
    endfunction

    task automatic close_run();
        $display("closing: %0d mismatches, %0d assertion failures, %0d timeouts",
                 mismatches, DUT.u_chk.assert_fails, timeouts);
        if (mismatches == 0 && DUT.u_chk.assert_fails == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic wait_until(input int which, input int limit, input string what);
        int n;
        n = 0;
        while (!cond_met(which) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!cond_met(which)) begin
            $display("timed out after %0d cycles waiting for %s", limit, what);
            timeouts++;
            close_run();
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic send_packet(input port_dir_e dir, input int len,
                               input flit_kind_e first_kind, input flit_kind_e last_kind);
        flit_kind_e kind;
        for (int i = 0; i < len; i++) begin
            if (i == 0) begin
                kind = first_kind;
            end else if (i == len - 1) begin
                kind = last_kind;
            end else begin
                kind = BODY;
            end
            // idle gap of 0 to 3 cycles stays far below the checker timeout.
            repeat ({rand_bit(), rand_bit()}) begin
                @(negedge clk);
                eject_valid[dir] = 1'b0;
            end
            @(negedge clk);
            eject_valid[dir] = 1'b1;
            eject_data[dir]  = {kind, (FLIT_W - KIND_W)'(i)};
        end
        @(negedge clk);
        eject_valid[dir] = 1'b0;
    endtask

    task automatic send_good(input port_dir_e dir, input int count);
        repeat (count) send_packet(dir, PACKET_SIZE, HEAD, TAIL);
    endtask

    task automatic strobe_check(input logic all_rcvd);
        exp_all = all_rcvd;
        @(negedge clk);
        check_en = 1'b1;
        @(negedge clk);
        check_en = 1'b0;
    endtask

    // ready about three cycles in four; xpos can be starved.
    initial begin
        forever begin
            @(negedge clk);
            for (int d = 0; d < NUM_DIRS; d++) begin
                inject_ready[d] = (rand_bit() | rand_bit()) && !(d == XPOS && hold_xpos);
            end
        end
    end

    initial begin
        for (int d = 0; d < NUM_DIRS; d++) begin
            eject_valid[d]  = 1'b0;
            eject_data[d]   = '0;
            inject_ready[d] = 1'b0;
            exp_count[d]    = 0;
            exp_err[d]      = NO_ERROR;
            for (int n = 0; n < TOTAL_FLITS; n++) begin
                exp_flits[d*TOTAL_FLITS + n] =
                    expected_flit(port_dir_e'(d), n / PACKET_SIZE, n % PACKET_SIZE);
            end
        end
        apply_reset();

        // back-pressure on xpos while the negative ports get clean packets.
        fork
            begin
                wait_until(W_XPOS_FULL, 4000, "the XPOS FIFO to fill");
                repeat (20) @(negedge clk);
                hold_xpos = 1'b0;
            end
            send_good(XNEG, 3);
            send_good(YNEG, 3);
            send_good(ZNEG, 3);
        join
        wait_until(W_INJECT_DONE, 20000, "every inject flit");
        exp_count = '{0, 0, 0, 3, 3, 3};
        strobe_check(1'b0);

        // early tail, stray body, and a head left hanging.
        fork
            send_packet(XNEG, 5, HEAD, TAIL);
            send_packet(YNEG, 1, BODY, BODY);
            send_packet(ZNEG, 1, HEAD, HEAD);
        join
        wait_until(W_ERRORS, 200, "error codes on the negative ports");
        exp_err = '{NO_ERROR, NO_ERROR, NO_ERROR, FLIT_MISSING, FLIT_WRONG, FLIT_TIMEOUT};
        strobe_check(1'b0);

        apply_reset();
        exp_err = '{default: NO_ERROR};
        fork
            send_good(XPOS, PACKET_NUM);
            send_good(YPOS, PACKET_NUM);
            send_good(ZPOS, PACKET_NUM);
            send_good(XNEG, PACKET_NUM);
            send_good(YNEG, PACKET_NUM);
            send_good(ZNEG, PACKET_NUM - 1);
        join
        // the last zneg packet waits for its tail.
        send_packet(ZNEG, PACKET_SIZE - 1, HEAD, BODY);
        exp_count       = '{default: PACKET_NUM};
        exp_count[ZNEG] = PACKET_NUM - 1;
        strobe_check(1'b0);
        send_packet(ZNEG, 1, TAIL, TAIL);
        wait_until(W_ALL_RCVD, 20, "all_pckts_rcvd");
        exp_count[ZNEG] = PACKET_NUM;
        strobe_check(1'b1);
        repeat (10) @(negedge clk);
        strobe_check(1'b1);
        wait_until(W_INJECT_DONE, 20000, "every inject flit after reset");
        close_run();
    end

endmodule

//--- local_unit.f
hw/noc_pkg.sv
hw/injection_pacer.sv
hw/flit_formatter.sv
hw/inject_fifo.sv
hw/eject_checker.sv
hw/local_unit.sv
tests/local_unit_chk.sv
tests/local_unit_mon.sv
tests/tb_local_unit.sv
